// ==== files.f ====
rvc_pkg.sv
rvc_pipe_reg.sv
rvc_classify.sv
rvc_expand.sv
rvc_decoder_top.sv
rvc_decoder_assertions.sv
tb_rvc_decoder.sv

// ==== Makefile ====
# Verilator flow for the compressed instruction decoder

TOP := tb_rvc_decoder

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f files.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f files.f -o $(TOP)
	-./obj_dir/$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "TEST FAILED" sim.log || ! grep -q "TEST PASSED" sim.log; then \
		echo "simulation failed, see sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// ==== tb_rvc_decoder.sv ====
// testbench for the compressed instruction decoder
// directed tests over both stream interfaces, expected words from the rvc encodings

`timescale 1ns/1ns

module tb_rvc_decoder
    import rvc_pkg::*;
();

    localparam int          CLK_PERIOD = 20;
    localparam int          TIMEOUT    = 200;
    localparam logic [31:0] LFSR_SEED  = 32'h9d188108;

    logic        clk;
    logic        arst_n;
    logic        in_valid;
    rvc_fetch_t  in_data;
    logic        in_ready;
    logic        out_valid;
    rvc_result_t out_data;
    logic        out_ready;

    logic [31:0] lfsr_state;
    int          cycle = 0;

    // words waiting to be streamed and what must come back
    logic [31:0] in_q[$];
    rvc_result_t exp_q[$];
    int          accept_q[$];

    // every pair checked so far, reused by the mixed stream
    logic [31:0] known_word[$];
    rvc_result_t known_exp[$];

    rvc_decoder_top u_rvc_decoder_top (
        .clk_i       (clk),
        .arst_n_i    (arst_n),
        .in_valid_i  (in_valid),
        .in_data_i   (in_data),
        .in_ready_o  (in_ready),
        .out_valid_o (out_valid),
        .out_data_o  (out_data),
        .out_ready_i (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // ------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------
    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r          = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic next_ready(input logic random_ready);
        if (random_ready) begin
            return rand_bits(1) != 32'd0;
        end else begin
            return 1'b1;
        end
    endfunction

    function automatic rvc_result_t make_result(input logic [31:0] instr,
                                                input logic illegal, input logic compressed);
        rvc_result_t r;
        r.instr      = instr;
        r.illegal    = illegal;
        r.compressed = compressed;
        return r;
    endfunction

    task automatic add_case(input logic [31:0] word, input logic [31:0] instr,
                            input logic illegal, input logic compressed);
        in_q.push_back(word);
        exp_q.push_back(make_result(instr, illegal, compressed));
        known_word.push_back(word);
        known_exp.push_back(make_result(instr, illegal, compressed));
    endtask

    // pair is {halfword, expected expansion}
    task automatic add_legal(input logic [47:0] pair);
        add_case({16'h0000, pair[47:32]}, pair[31:0], 1'b0, 1'b1);
    endtask

    // ------------------------------------------------------------------
    // stream drivers, inputs change 1 ns after the edge, sampled at negedge
    // ------------------------------------------------------------------
    task automatic send_word(input logic [31:0] word);
        int waited;
        waited        = 0;
        in_valid      = 1'b1;
        in_data.instr = word;
        @(negedge clk);
        while (!in_ready) begin
            waited++;
            if (waited > TIMEOUT) stop_run("timeout, the decoder never accepted a word");
            @(negedge clk);
        end
        accept_q.push_back(cycle);
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic expect_word(input logic [31:0] word, input rvc_result_t exp,
                               input logic random_ready, input logic check_latency);
        rvc_result_t got;
        int          waited;
        int          sent_at;
        waited    = 0;
        out_ready = next_ready(random_ready);
        @(negedge clk);
        while (!(out_valid && out_ready)) begin
            waited++;
            if (waited > TIMEOUT) stop_run("timeout, no output word arrived");
            @(posedge clk);
            #1;
            out_ready = next_ready(random_ready);
            @(negedge clk);
        end
        got     = out_data;
        sent_at = accept_q.pop_front();
        assert (got.instr == exp.instr) else
            stop_run($sformatf("Mismatch at %0t: instr %h, expected %h, input %h",
                               $time, got.instr, exp.instr, word));
        assert (got.illegal == exp.illegal) else
            stop_run($sformatf("Mismatch at %0t: illegal %b, expected %b, input %h",
                               $time, got.illegal, exp.illegal, word));
        assert (got.compressed == exp.compressed) else
            stop_run($sformatf("Mismatch at %0t: compressed %b, expected %b, input %h",
                               $time, got.compressed, exp.compressed, word));
        assert (!check_latency || (cycle - sent_at == 2)) else
            stop_run($sformatf("Mismatch at %0t: latency %0d cycles, expected 2, input %h",
                               $time, cycle - sent_at, word));
        @(posedge clk);
        #1;
    endtask

    task automatic run_stream(input logic random_ready, input string name);
        fork
            begin
                foreach (in_q[i]) send_word(in_q[i]);
            end
            begin
                foreach (exp_q[i]) expect_word(in_q[i], exp_q[i], random_ready, !random_ready);
            end
        join
        $display("%s: %0d words checked", name, exp_q.size());
        in_q.delete();
        exp_q.delete();
        out_ready = 1'b0;
    endtask

    // ------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------
    task automatic test_pass_through();
        logic [31:0] word;
        for (int i = 0; i < 8; i++) begin
            word = rand_bits(32) | 32'h0000_0003;
            add_case(word, word, 1'b0, 1'b0);
        end
        run_stream(1'b0, "pass-through");
    endtask

    task automatic test_memory_forms();
        logic [47:0] pairs [5] = '{
            {16'h0040, 32'h0041_0413},   // c.addi4spn x8, sp, 4
            {16'h4144, 32'h0045_2483},   // c.lw x9, 4(x10)
            {16'hc144, 32'h0095_2223},   // c.sw x9, 4(x10)
            {16'h40a2, 32'h0081_2083},   // c.lwsp ra, 8
            {16'hc406, 32'h0011_2423}    // c.swsp ra, 8
        };
        foreach (pairs[i]) add_legal(pairs[i]);
        run_stream(1'b0, "memory forms");
    endtask

    task automatic test_arith_control();
        logic [47:0] pairs [22] = '{
            {16'h10fd, 32'hfff0_8093}, {16'h4515, 32'h0050_0513},
            {16'h6505, 32'h0000_1537}, {16'h6141, 32'h0101_0113},
            {16'h8005, 32'h0014_5413}, {16'h8405, 32'h4014_5413},
            {16'h987d, 32'hfff4_7413}, {16'h8c05, 32'h4094_0433},
            {16'h8c25, 32'h0094_4433}, {16'h8c45, 32'h0094_6433},
            {16'h8c65, 32'h0094_7433}, {16'hbffd, 32'hffff_f06f},
            {16'h3ffd, 32'hffff_f0ef}, {16'hc009, 32'h0004_0163},
            {16'he009, 32'h0004_1163}, {16'hdcfd, 32'hfe04_8fe3},
            // quadrant 2 register forms
            {16'h0086, 32'h0010_9093}, {16'h808a, 32'h0020_00b3},
            {16'h908a, 32'h0020_80b3}, {16'h8082, 32'h0000_8067},
            {16'h9082, 32'h0000_80e7}, {16'h9002, 32'h0010_0073}
        };
        foreach (pairs[i]) add_legal(pairs[i]);
        run_stream(1'b0, "arithmetic and control");
    endtask

    task automatic test_illegal();
        // reserved zeros, then fp, then rv64 subw/addw and the reserved c0 slot
        logic [15:0] words [16] = '{
            16'h0000, 16'h6501, 16'h6101, 16'h4012, 16'h8002,
            16'h2000, 16'h6000, 16'ha000, 16'he000,
            16'h2002, 16'h6002, 16'ha002, 16'he002,
            16'h9c05, 16'h9c25, 16'h8000
        };
        foreach (words[i]) add_case({16'h0000, words[i]}, {16'h0000, words[i]}, 1'b1, 1'b1);
        run_stream(1'b0, "illegal encodings");
    endtask

    task automatic test_backpressure();
        logic [31:0] word;
        int          idx;
        // both stages fill, then the input side has to stall
        out_ready = 1'b0;
        send_word(32'h0000_8082);
        send_word(32'h0000_4515);
        @(negedge clk);
        assert (!in_ready) else stop_run("input stayed ready with both stages full");
        @(posedge clk);
        #1;
        expect_word(32'h0000_8082, make_result(32'h0000_8067, 1'b0, 1'b1), 1'b0, 1'b0);
        expect_word(32'h0000_4515, make_result(32'h0050_0513, 1'b0, 1'b1), 1'b0, 1'b0);
        out_ready = 1'b0;

        for (int i = 0; i < 40; i++) begin
            if (rand_bits(1) != 32'd0) begin
                word = rand_bits(32) | 32'h0000_0003;
                in_q.push_back(word);
                exp_q.push_back(make_result(word, 1'b0, 1'b0));
            end else begin
                idx = int'(rand_bits(8)) % known_word.size();
                in_q.push_back(known_word[idx]);
                exp_q.push_back(known_exp[idx]);
            end
        end
        run_stream(1'b1, "mixed stream with back-pressure");

        // nothing may follow the last word of the stream
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            assert (!out_valid) else stop_run("extra output word after the mixed stream");
        end
    endtask

    // ------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------
    initial begin
        lfsr_state = LFSR_SEED;
        arst_n     = 1'b1;
        in_valid   = 1'b0;
        in_data    = '0;
        out_ready  = 1'b0;
        #1;
        arst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;
        @(negedge clk);
        assert (!out_valid && in_ready) else stop_run("stream flags wrong after reset");
        @(posedge clk);
        #1;

        test_pass_through();
        test_memory_forms();
        test_arith_control();
        test_illegal();
        test_backpressure();

        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== rvc_decoder_assertions.sv ====
// stream checks for the compressed instruction decoder
// bound into the top level, watches the output stream

`timescale 1ns/1ns

module rvc_decoder_assertions
    import rvc_pkg::*;
(
    input logic        clk_i,
    input logic        arst_n_i,
    input logic        valid_i,
    input rvc_result_t data_i,
    input logic        ready_i
);

    // a stalled word holds still until it is taken
    property p_stall_stable;
        @(posedge clk_i) disable iff (!arst_n_i)
        (valid_i && !ready_i) |=> (valid_i && $stable(data_i));
    endproperty

    // only a compressed halfword can be illegal
    property p_illegal_compressed;
        @(posedge clk_i) disable iff (!arst_n_i)
        valid_i |-> (!data_i.illegal || data_i.compressed);
    endproperty

    property p_reset_idle;
        @(posedge clk_i) !arst_n_i |-> !valid_i;
    endproperty

    a_stall_stable: assert property (p_stall_stable)
        else $error("output word changed or vanished while stalled");

    a_illegal_compressed: assert property (p_illegal_compressed)
        else $error("illegal flag set on an uncompressed word");

    a_reset_idle: assert property (p_reset_idle)
        else $error("output valid high during reset");

endmodule

bind rvc_decoder_top rvc_decoder_assertions u_rvc_decoder_assertions (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (out_valid_o),
    .data_i   (out_data_o),
    .ready_i  (out_ready_i)
);

// ==== rvc_decoder_top.sv ====
// compressed instruction decoder
// two-stage valid/ready pipeline, classify then expand

`timescale 1ns/1ns

module rvc_decoder_top
    import rvc_pkg::*;
(
    input  logic        clk_i,
    input  logic        arst_n_i,

    // fetch stream
    input  logic        in_valid_i,
    input  rvc_fetch_t  in_data_i,
    output logic        in_ready_o,

    // expanded instruction stream
    output logic        out_valid_o,
    output rvc_result_t out_data_o,
    input  logic        out_ready_i
);

    // ------------------------------------------------------------------
    // classify to expand
    // ------------------------------------------------------------------
    logic       class_valid;
    logic       class_ready;
    rvc_class_t class_data;

    rvc_classify u_rvc_classify (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .in_valid_i  (in_valid_i),
        .in_data_i   (in_data_i),
        .in_ready_o  (in_ready_o),
        .out_valid_o (class_valid),
        .out_data_o  (class_data),
        .out_ready_i (class_ready)
    );

    rvc_expand u_rvc_expand (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .in_valid_i  (class_valid),
        .in_data_i   (class_data),
        .in_ready_o  (class_ready),
        .out_valid_o (out_valid_o),
        .out_data_o  (out_data_o),
        .out_ready_i (out_ready_i)
    );

endmodule

// ==== rvc_expand.sv ====
// expand stage
// builds the 32-bit instruction from the operation code and the raw halfword

`timescale 1ns/1ns

module rvc_expand
    import rvc_pkg::*;
(
    input  logic        clk_i,
    input  logic        arst_n_i,

    input  logic        in_valid_i,
    input  rvc_class_t  in_data_i,
    output logic        in_ready_o,

    output logic        out_valid_o,
    output rvc_result_t out_data_o,
    input  logic        out_ready_i
);

    logic [CLEN-1:0] c;
    logic [4:0]      rd;
    logic [4:0]      rs2;
    logic [4:0]      rp_hi;
    logic [4:0]      rp_lo;
    logic [ILEN-1:0] instr_d;
    rvc_result_t     result_d;

    assign c   = in_data_i.raw[CLEN-1:0];
    assign rd  = c[11:7];
    assign rs2 = c[6:2];

    // rs1'/rd' sits in [9:7], rs2'/rd' in [4:2]
    assign rp_hi = {RVC_REG_BASE, c[9:7]};
    assign rp_lo = {RVC_REG_BASE, c[4:2]};

    // ------------------------------------------------------------------
    // field scatter
    // I: imm[11:0] | rs1 | funct3 | rd | opcode
    // S: imm[11:5] | rs2 | rs1 | funct3 | imm[4:0] | opcode
    // ------------------------------------------------------------------
    always_comb begin
        instr_d = in_data_i.raw;

        unique case (in_data_i.op)
            // quadrant 0
            OP_ADDI4SPN: instr_d = {2'b0, c[10:7], c[12:11], c[5], c[6], 2'b00,
                                    REG_SP, 3'b000, rp_lo, OPC_OP_IMM};
            OP_LW:       instr_d = {5'b0, c[5], c[12:10], c[6], 2'b00,
                                    rp_hi, 3'b010, rp_lo, OPC_LOAD};
            OP_SW:       instr_d = {5'b0, c[5], c[12], rp_lo, rp_hi, 3'b010,
                                    c[11:10], c[6], 2'b00, OPC_STORE};

            // quadrant 1, immediates
            OP_ADDI:     instr_d = {{6{c[12]}}, c[12], c[6:2], rd, 3'b000, rd, OPC_OP_IMM};
            OP_LI:       instr_d = {{6{c[12]}}, c[12], c[6:2], REG_ZERO, 3'b000, rd,
                                    OPC_OP_IMM};
            OP_LUI:      instr_d = {{15{c[12]}}, c[6:2], rd, OPC_LUI};
            OP_ADDI16SP: instr_d = {{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0,
                                    REG_SP, 3'b000, REG_SP, OPC_OP_IMM};

            // shamt[5] is carried along as in the encoding
            OP_SRLI:     instr_d = {6'b000000, c[12], c[6:2], rp_hi, 3'b101, rp_hi,
                                    OPC_OP_IMM};
            OP_SRAI:     instr_d = {6'b010000, c[12], c[6:2], rp_hi, 3'b101, rp_hi,
                                    OPC_OP_IMM};
            OP_ANDI:     instr_d = {{6{c[12]}}, c[12], c[6:2], rp_hi, 3'b111, rp_hi,
                                    OPC_OP_IMM};

            // quadrant 1, register-register on x8..x15
            OP_SUB:      instr_d = {7'b0100000, rp_lo, rp_hi, 3'b000, rp_hi, OPC_OP};
            OP_XOR:      instr_d = {7'b0000000, rp_lo, rp_hi, 3'b100, rp_hi, OPC_OP};
            OP_OR:       instr_d = {7'b0000000, rp_lo, rp_hi, 3'b110, rp_hi, OPC_OP};
            OP_AND:      instr_d = {7'b0000000, rp_lo, rp_hi, 3'b111, rp_hi, OPC_OP};

            // jumps, J offset is imm[20|10:1|11|19:12]
            OP_JAL:      instr_d = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                                    {9{c[12]}}, REG_RA, OPC_JAL};
            OP_J:        instr_d = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                                    {9{c[12]}}, REG_ZERO, OPC_JAL};

            // branches compare rs1' against x0
            OP_BEQZ:     instr_d = {{4{c[12]}}, c[6:5], c[2], REG_ZERO, rp_hi, 3'b000,
                                    c[11:10], c[4:3], c[12], OPC_BRANCH};
            OP_BNEZ:     instr_d = {{4{c[12]}}, c[6:5], c[2], REG_ZERO, rp_hi, 3'b001,
                                    c[11:10], c[4:3], c[12], OPC_BRANCH};

            // quadrant 2
            OP_SLLI:     instr_d = {6'b0, c[12], c[6:2], rd, 3'b001, rd, OPC_OP_IMM};
            OP_LWSP:     instr_d = {4'b0, c[3:2], c[12], c[6:4], 2'b00,
                                    REG_SP, 3'b010, rd, OPC_LOAD};
            OP_SWSP:     instr_d = {4'b0, c[8:7], c[12], rs2, REG_SP, 3'b010,
                                    c[11:9], 2'b00, OPC_STORE};
            OP_JR:       instr_d = {12'b0, rd, 3'b000, REG_ZERO, OPC_JALR};
            OP_JALR:     instr_d = {12'b0, rd, 3'b000, REG_RA, OPC_JALR};
            OP_MV:       instr_d = {7'b0, rs2, REG_ZERO, 3'b000, rd, OPC_OP};
            OP_ADD:      instr_d = {7'b0, rs2, rd, 3'b000, rd, OPC_OP};
            OP_EBREAK:   instr_d = OPC_SYSTEM_EBREAK;

            // full words and illegal halfwords go out as they came in
            default:     instr_d = in_data_i.raw;
        endcase
    end

    assign result_d = '{
        instr:      instr_d,
        illegal:    in_data_i.illegal,
        compressed: in_data_i.compressed
    };

    rvc_pipe_reg #(
        .payload_t (rvc_result_t)
    ) u_pipe_reg (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .valid_i  (in_valid_i),
        .data_i   (result_d),
        .ready_o  (in_ready_o),
        .valid_o  (out_valid_o),
        .data_o   (out_data_o),
        .ready_i  (out_ready_i)
    );

endmodule

// ==== rvc_classify.sv ====
// classify stage
// maps a fetch word to an operation code with illegal and compressed flags

`timescale 1ns/1ns

module rvc_classify
    import rvc_pkg::*;
(
    input  logic       clk_i,
    input  logic       arst_n_i,

    input  logic       in_valid_i,
    input  rvc_fetch_t in_data_i,
    output logic       in_ready_o,

    output logic       out_valid_o,
    output rvc_class_t out_data_o,
    input  logic       out_ready_i
);

    logic [1:0] quad;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [4:0] rs2;
    rvc_op_e    op_d;
    logic       illegal_d;
    logic       compressed_d;
    rvc_class_t class_d;

    assign quad   = in_data_i.instr[1:0];
    assign funct3 = in_data_i.instr[15:13];
    assign rd     = in_data_i.instr[11:7];
    assign rs2    = in_data_i.instr[6:2];

    // ------------------------------------------------------------------
    // decode
    // ------------------------------------------------------------------
    always_comb begin
        op_d         = OP_FULL;
        illegal_d    = 1'b0;
        compressed_d = 1'b1;

        unique case (quad)
            QUAD_C0: begin
                unique case (funct3)
                    3'b000: begin
                        op_d      = OP_ADDI4SPN;
                        illegal_d = (in_data_i.instr[12:5] == 8'h00);
                    end
                    3'b010:  op_d = OP_LW;
                    3'b110:  op_d = OP_SW;
                    // fld, flw, fsd, fsw and the reserved slot
                    default: illegal_d = 1'b1;
                endcase
            end

            QUAD_C1: begin
                unique case (funct3)
                    3'b000: op_d = OP_ADDI;
                    3'b001: op_d = OP_JAL;
                    3'b010: op_d = OP_LI;
                    3'b011: begin
                        op_d      = (rd == REG_SP) ? OP_ADDI16SP : OP_LUI;
                        illegal_d = ({in_data_i.instr[12], rs2} == 6'b0);
                    end
                    3'b100: begin
                        unique case (in_data_i.instr[11:10])
                            2'b00: op_d = OP_SRLI;
                            2'b01: op_d = OP_SRAI;
                            2'b10: op_d = OP_ANDI;
                            default: begin
                                unique case ({in_data_i.instr[12], in_data_i.instr[6:5]})
                                    3'b000:  op_d = OP_SUB;
                                    3'b001:  op_d = OP_XOR;
                                    3'b010:  op_d = OP_OR;
                                    3'b011:  op_d = OP_AND;
                                    // subw, addw and reserved
                                    default: illegal_d = 1'b1;
                                endcase
                            end
                        endcase
                    end
                    3'b101:  op_d = OP_J;
                    3'b110:  op_d = OP_BEQZ;
                    default: op_d = OP_BNEZ;
                endcase
            end

            QUAD_C2: begin
                unique case (funct3)
                    3'b000: op_d = OP_SLLI;
                    3'b010: begin
                        op_d      = OP_LWSP;
                        illegal_d = (rd == REG_ZERO);
                    end
                    3'b100: begin
                        if (!in_data_i.instr[12]) begin
                            op_d      = (rs2 == REG_ZERO) ? OP_JR : OP_MV;
                            illegal_d = (rs2 == REG_ZERO) && (rd == REG_ZERO);
                        end else if (rs2 != REG_ZERO) begin
                            op_d = OP_ADD;
                        end else begin
                            op_d = (rd == REG_ZERO) ? OP_EBREAK : OP_JALR;
                        end
                    end
                    3'b110:  op_d = OP_SWSP;
                    // the sp-relative fp and rv64 forms
                    default: illegal_d = 1'b1;
                endcase
            end

            QUAD_FULL: compressed_d = 1'b0;
        endcase

        if (illegal_d) begin
            op_d = OP_ILLEGAL;
        end
    end

    assign class_d = '{
        raw:        in_data_i.instr,
        op:         op_d,
        illegal:    illegal_d,
        compressed: compressed_d
    };

    rvc_pipe_reg #(
        .payload_t (rvc_class_t)
    ) u_pipe_reg (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .valid_i  (in_valid_i),
        .data_i   (class_d),
        .ready_o  (in_ready_o),
        .valid_o  (out_valid_o),
        .data_o   (out_data_o),
        .ready_i  (out_ready_i)
    );

endmodule

// ==== rvc_pipe_reg.sv ====
// pipeline stage register
// holds one payload with its valid bit on a valid/ready stream

`timescale 1ns/1ns

module rvc_pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     arst_n_i,

    input  logic     valid_i,
    input  payload_t data_i,
    output logic     ready_o,

    output logic     valid_o,
    output payload_t data_o,
    input  logic     ready_i
);

    logic     full_q;
    payload_t data_q;

    // take a new word when empty or when the held one leaves this cycle
    assign ready_o = ~full_q | ready_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            full_q <= 1'b0;
        end else if (ready_o) begin
            full_q <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i && ready_o) begin
            data_q <= data_i;
        end
    end

    assign valid_o = full_q;
    assign data_o  = data_q;

endmodule

// ==== rvc_pkg.sv ====
// rvc package
// shared widths, opcodes, register numbers and stage payloads for the
// RV32 compressed-instruction expander

package rvc_pkg;

    // ------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------
    localparam int ILEN = 32;
    localparam int CLEN = 16;

    // ------------------------------------------------------------------
    // major opcodes of the expanded word
    // ------------------------------------------------------------------
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    // ebreak has no operands, so the whole word is fixed
    localparam logic [ILEN-1:0] OPC_SYSTEM_EBREAK = 32'h0010_0073;

    // quadrant in bits [1:0] of the fetch word
    localparam logic [1:0] QUAD_C0   = 2'b00;
    localparam logic [1:0] QUAD_C1   = 2'b01;
    localparam logic [1:0] QUAD_C2   = 2'b10;
    localparam logic [1:0] QUAD_FULL = 2'b11;

    // register numbers implied by some compressed forms
    localparam logic [4:0] REG_ZERO = 5'd0;
    localparam logic [4:0] REG_RA   = 5'd1;
    localparam logic [4:0] REG_SP   = 5'd2;

    // 3-bit rd'/rs1'/rs2' fields address x8..x15
    localparam logic [1:0] RVC_REG_BASE = 2'b01;

    // ------------------------------------------------------------------
    // operation codes, one per supported compressed instruction
    // ------------------------------------------------------------------
    typedef enum logic [4:0] {
        OP_ADDI4SPN, OP_LW,    OP_SW,
        OP_ADDI,     OP_JAL,   OP_LI,    OP_LUI,   OP_ADDI16SP,
        OP_SRLI,     OP_SRAI,  OP_ANDI,  OP_SUB,   OP_XOR,
        OP_OR,       OP_AND,   OP_J,     OP_BEQZ,  OP_BNEZ,
        OP_SLLI,     OP_LWSP,  OP_SWSP,  OP_JR,    OP_MV,
        OP_EBREAK,   OP_JALR,  OP_ADD,
        OP_FULL,
        OP_ILLEGAL
    } rvc_op_e;

    // ------------------------------------------------------------------
    // stream payloads
    // ------------------------------------------------------------------
    typedef struct packed {
        logic [ILEN-1:0] instr;
    } rvc_fetch_t;

    // classify to expand, 39 bits
    typedef struct packed {
        logic [ILEN-1:0] raw;
        rvc_op_e         op;
        logic            illegal;
        logic            compressed;
    } rvc_class_t;

    // decoder output, 34 bits
    typedef struct packed {
        logic [ILEN-1:0] instr;
        logic            illegal;
        logic            compressed;
    } rvc_result_t;

endpackage
